//--- axis_bound.sv
// Per-axis bound unit that takes min and max over three vertices, floors and clips them
// One instance per screen axis feeds its registered box to the output stage
`timescale 1ns/1ps
`include "bbox_macros.svh"

module axis_bound (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stage_en,
    input  bbox_pkg::coord_t c_0,
    input  bbox_pkg::coord_t c_1,
    input  bbox_pkg::coord_t c_2,
    input  bbox_pkg::coord_t limit,
    input  bbox_pkg::msaa_t  msaa,
    output bbox_pkg::coord_t lo,
    output bbox_pkg::coord_t hi,
    output logic             off_screen,
    output bbox_pkg::coord_t d_0,
    output bbox_pkg::coord_t d_1,
    output bbox_pkg::coord_t d_2
);
    import bbox_pkg::*;

    logic [2:0]           lo_sel;
    logic [2:0]           hi_sel;
    coord_t               lo_raw;
    coord_t               hi_raw;
    logic [`BB_RADIX:0]   step_frac;
    coord_t               step;
    coord_t               floor_mask;
    coord_t               lo_rnd;
    coord_t               hi_rnd;
    logic                 off_next;

    // One-hot picks from pairwise compares where a tie goes to the later vertex
    assign lo_sel[0] = (c_0 < c_1) && (c_0 < c_2);
    assign lo_sel[1] = (c_1 <= c_0) && (c_1 < c_2);
    assign lo_sel[2] = (c_2 <= c_0) && (c_2 <= c_1);
    assign hi_sel[0] = (c_0 > c_1) && (c_0 > c_2);
    assign hi_sel[1] = (c_1 >= c_0) && (c_1 > c_2);
    assign hi_sel[2] = (c_2 >= c_0) && (c_2 >= c_1);

    // AND-OR mux on the one-hot selects
    assign lo_raw = ({`BB_SIGFIG{lo_sel[0]}} & c_0) |
                    ({`BB_SIGFIG{lo_sel[1]}} & c_1) |
                    ({`BB_SIGFIG{lo_sel[2]}} & c_2);
    assign hi_raw = ({`BB_SIGFIG{hi_sel[0]}} & c_0) |
                    ({`BB_SIGFIG{hi_sel[1]}} & c_1) |
                    ({`BB_SIGFIG{hi_sel[2]}} & c_2);

    // Grid step taken straight from the one-hot setting
    // 1000 gives 1024 and 0001 gives 128
    assign step_frac  = {msaa, {(`BB_RADIX - `BB_MSAA_W + 1){1'b0}}};
    assign step       = coord_t'(step_frac);
    assign floor_mask = ~(step - coord_t'(1));

    // Masking floors toward minus infinity for negatives too
    assign lo_rnd = lo_raw & floor_mask;
    assign hi_rnd = hi_raw & floor_mask;

    // Box lies wholly beyond one side of the screen on this axis
    assign off_next = (lo_rnd > limit) || (hi_rnd < 0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            off_screen <= 1'b0;
        end else if (stage_en) begin
            off_screen <= off_next;
        end
    end

    // Clipped box and delayed vertices
    always_ff @(posedge clk) begin
        if (stage_en) begin
            lo  <= (lo_rnd < 0) ? '0 : lo_rnd;
            hi  <= (hi_rnd > limit) ? limit : hi_rnd;
            d_0 <= c_0;
            d_1 <= c_1;
            d_2 <= c_2;
        end
    end

    // Selects must each name exactly one vertex
    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(lo_sel) && $onehot(hi_sel));

    // Min/max pick is consistent
    a_raw_order: assert property (@(posedge clk) disable iff (!rst_n)
        !(hi_raw < lo_raw));

    // Floor never moves a bound by a full grid step or more
    a_floor_err: assert property (@(posedge clk) disable iff (!rst_n)
        ((lo_raw - lo_rnd) < step) && ((hi_raw - hi_rnd) < step));

endmodule

//--- bbox_macros.svh
// Width and geometry constants for the bounding-box pipeline
// Include in any file that sizes coordinates, vertices or the sample setting
`ifndef BBOX_MACROS_SVH
`define BBOX_MACROS_SVH

// Total bits of one signed fixed-point coordinate
`define BB_SIGFIG 24

// Fraction bits, one pixel spans 1 << BB_RADIX units
`define BB_RADIX 10

// Vertices per triangle
`define BB_VERTS 3

// Screen axes handled, x first then y
`define BB_AXES 2

// Width of the one-hot MSAA setting
`define BB_MSAA_W 4

`endif

//--- bbox_output_stage.sv
// Last pipeline stage, merges the reject flags into out_valid and holds results
// Also owns the shared enable that freezes the pipe on halt
`timescale 1ns/1ps
`include "bbox_macros.svh"

module bbox_output_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             halt,
    input  logic             s2_valid,
    input  logic             backfacing,
    input  logic             off_x,
    input  logic             off_y,
    input  bbox_pkg::coord_t lo_x,
    input  bbox_pkg::coord_t hi_x,
    input  bbox_pkg::coord_t lo_y,
    input  bbox_pkg::coord_t hi_y,
    input  bbox_pkg::coord_t dx_0,
    input  bbox_pkg::coord_t dx_1,
    input  bbox_pkg::coord_t dx_2,
    input  bbox_pkg::coord_t dy_0,
    input  bbox_pkg::coord_t dy_1,
    input  bbox_pkg::coord_t dy_2,
    output logic             stage_en,
    output logic             out_valid,
    output bbox_pkg::coord_t box_ll_x,
    output bbox_pkg::coord_t box_ll_y,
    output bbox_pkg::coord_t box_ur_x,
    output bbox_pkg::coord_t box_ur_y,
    output bbox_pkg::coord_t out_v0_x,
    output bbox_pkg::coord_t out_v0_y,
    output bbox_pkg::coord_t out_v1_x,
    output bbox_pkg::coord_t out_v1_y,
    output bbox_pkg::coord_t out_v2_x,
    output bbox_pkg::coord_t out_v2_y
);
    import bbox_pkg::*;

    logic keep;

    // Only a real triangle on screen and front-facing survives
    assign keep = s2_valid && !backfacing && !off_x && !off_y;

    // Freeze only when a valid result is being held,
    // a bubble at the output never blocks the pipe
    assign stage_en = !halt || !out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (stage_en) begin
            out_valid <= keep;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_en) begin
            box_ll_x <= lo_x;
            box_ll_y <= lo_y;
            box_ur_x <= hi_x;
            box_ur_y <= hi_y;
            out_v0_x <= dx_0;
            out_v1_x <= dx_1;
            out_v2_x <= dx_2;
            out_v0_y <= dy_0;
            out_v1_y <= dy_1;
            out_v2_y <= dy_2;
        end
    end

    // Kept boxes are never inverted after clipping
    a_box_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (box_ll_x <= box_ur_x) && (box_ll_y <= box_ur_y));

    // Held result stays put until downstream takes it
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && halt) |=> out_valid
            && $stable(box_ll_x) && $stable(box_ll_y)
            && $stable(box_ur_x) && $stable(box_ur_y)
            && $stable(out_v0_x) && $stable(out_v0_y)
            && $stable(out_v1_x) && $stable(out_v1_y)
            && $stable(out_v2_x) && $stable(out_v2_y));

endmodule

//--- bbox_pkg.sv
// Shared data types for the bounding-box pipeline
// Modules import this inside their body and name types with bbox_pkg:: in port lists
`include "bbox_macros.svh"

package bbox_pkg;

    // Signed fixed-point coordinate
    // Upper bits hold the integer part, low BB_RADIX bits the fraction
    typedef logic signed [`BB_SIGFIG-1:0] coord_t;

    // Full-precision cross-product term, wide enough for coord_t * coord_t
    typedef logic signed [2*`BB_SIGFIG-1:0] product_t;

    // One-hot sample setting
    // 1000 gives 1 sample per pixel, grid step 1024
    // 0100 gives 4 samples, step 512
    // 0010 gives 16 samples, step 256
    // 0001 gives 64 samples, step 128
    typedef logic [`BB_MSAA_W-1:0] msaa_t;

endpackage

//--- bbox_top.sv
// Bounding-box stage top, three cycles from accepted triangle to output
// Setup, then per-axis bounds with the facing test in parallel, then output
`timescale 1ns/1ps
`include "bbox_macros.svh"

module bbox_top (
    input  logic             clk,
    input  logic             rst_n,
    input  bbox_pkg::coord_t v0_x,
    input  bbox_pkg::coord_t v0_y,
    input  bbox_pkg::coord_t v1_x,
    input  bbox_pkg::coord_t v1_y,
    input  bbox_pkg::coord_t v2_x,
    input  bbox_pkg::coord_t v2_y,
    input  logic             in_valid,
    output logic             in_ready,
    input  bbox_pkg::coord_t screen_w,
    input  bbox_pkg::coord_t screen_h,
    input  bbox_pkg::msaa_t  msaa,
    input  logic             halt,
    output logic             out_valid,
    output bbox_pkg::coord_t box_ll_x,
    output bbox_pkg::coord_t box_ll_y,
    output bbox_pkg::coord_t box_ur_x,
    output bbox_pkg::coord_t box_ur_y,
    output bbox_pkg::coord_t out_v0_x,
    output bbox_pkg::coord_t out_v0_y,
    output bbox_pkg::coord_t out_v1_x,
    output bbox_pkg::coord_t out_v1_y,
    output bbox_pkg::coord_t out_v2_x,
    output bbox_pkg::coord_t out_v2_y
);
    import bbox_pkg::*;

    logic   stage_en;
    logic   s1_valid;
    logic   s2_valid;
    logic   backfacing;
    coord_t ax;
    coord_t ay;
    coord_t bx;
    coord_t by;

    // Per-axis buses, index 0 is x and index 1 is y
    coord_t axis_c     [`BB_AXES][`BB_VERTS];
    coord_t axis_d     [`BB_AXES][`BB_VERTS];
    coord_t axis_limit [`BB_AXES];
    coord_t axis_lo    [`BB_AXES];
    coord_t axis_hi    [`BB_AXES];
    logic   axis_off   [`BB_AXES];

    // Upstream may hand over a triangle whenever the pipe advances
    assign in_ready = stage_en;

    assign axis_limit[0] = screen_w;
    assign axis_limit[1] = screen_h;

    tri_setup u_setup (
        .clk      (clk),
        .rst_n    (rst_n),
        .stage_en (stage_en),
        .v0_x     (v0_x),
        .v0_y     (v0_y),
        .v1_x     (v1_x),
        .v1_y     (v1_y),
        .v2_x     (v2_x),
        .v2_y     (v2_y),
        .in_valid (in_valid),
        .x_0      (axis_c[0][0]),
        .x_1      (axis_c[0][1]),
        .x_2      (axis_c[0][2]),
        .y_0      (axis_c[1][0]),
        .y_1      (axis_c[1][1]),
        .y_2      (axis_c[1][2]),
        .s1_valid (s1_valid),
        .ax       (ax),
        .ay       (ay),
        .bx       (bx),
        .by       (by)
    );

    for (genvar k = 0; k < `BB_AXES; k++) begin : g_axis
        axis_bound u_bound (
            .clk        (clk),
            .rst_n      (rst_n),
            .stage_en   (stage_en),
            .c_0        (axis_c[k][0]),
            .c_1        (axis_c[k][1]),
            .c_2        (axis_c[k][2]),
            .limit      (axis_limit[k]),
            .msaa       (msaa),
            .lo         (axis_lo[k]),
            .hi         (axis_hi[k]),
            .off_screen (axis_off[k]),
            .d_0        (axis_d[k][0]),
            .d_1        (axis_d[k][1]),
            .d_2        (axis_d[k][2])
        );
    end

    facing_test u_facing (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage_en   (stage_en),
        .ax         (ax),
        .ay         (ay),
        .bx         (bx),
        .by         (by),
        .s1_valid   (s1_valid),
        .s2_valid   (s2_valid),
        .backfacing (backfacing)
    );

    bbox_output_stage u_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt       (halt),
        .s2_valid   (s2_valid),
        .backfacing (backfacing),
        .off_x      (axis_off[0]),
        .off_y      (axis_off[1]),
        .lo_x       (axis_lo[0]),
        .hi_x       (axis_hi[0]),
        .lo_y       (axis_lo[1]),
        .hi_y       (axis_hi[1]),
        .dx_0       (axis_d[0][0]),
        .dx_1       (axis_d[0][1]),
        .dx_2       (axis_d[0][2]),
        .dy_0       (axis_d[1][0]),
        .dy_1       (axis_d[1][1]),
        .dy_2       (axis_d[1][2]),
        .stage_en   (stage_en),
        .out_valid  (out_valid),
        .box_ll_x   (box_ll_x),
        .box_ll_y   (box_ll_y),
        .box_ur_x   (box_ur_x),
        .box_ur_y   (box_ur_y),
        .out_v0_x   (out_v0_x),
        .out_v0_y   (out_v0_y),
        .out_v1_x   (out_v1_x),
        .out_v1_y   (out_v1_y),
        .out_v2_x   (out_v2_x),
        .out_v2_y   (out_v2_y)
    );

endmodule

//--- compile.f
+incdir+.
bbox_pkg.sv
tri_setup.sv
axis_bound.sv
facing_test.sv
bbox_output_stage.sv
bbox_top.sv
tb_bbox.sv

//--- facing_test.sv
// Winding test, registers the two cross-product terms alongside the valid flag
// The subtraction after the register gives the back-facing flag
`timescale 1ns/1ps
`include "bbox_macros.svh"

module facing_test (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stage_en,
    input  bbox_pkg::coord_t ax,
    input  bbox_pkg::coord_t ay,
    input  bbox_pkg::coord_t bx,
    input  bbox_pkg::coord_t by,
    input  logic             s1_valid,
    output logic             s2_valid,
    output logic             backfacing
);
    import bbox_pkg::*;

    product_t prod_l;
    product_t prod_r;
    product_t cross_z;

    // Valid flag tracks the bound units, same latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (stage_en) begin
            s2_valid <= s1_valid;
        end
    end

    // Full-width signed products of the edge components
    always_ff @(posedge clk) begin
        if (stage_en) begin
            prod_l <= product_t'(ax) * product_t'(by);
            prod_r <= product_t'(ay) * product_t'(bx);
        end
    end

    // z of A x B, no overflow since each term stays under 2^(2*SIGFIG-2)
    assign cross_z = prod_l - prod_r;

    // Positive z means clockwise, which this raster treats as back-facing
    assign backfacing = (cross_z > 0);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bounding-box testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bbox -f compile.f > build.log 2>&1 \
    && ./obj_dir/Vtb_bbox > sim.log 2>&1 \
    || echo "Build or simulation ended with an error, see build.log and sim.log"

grep -qx "Simulation passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

exit 0

//--- tb_bbox.sv
// Self-checking testbench for the bounding-box pipeline
// Directed and random triangles checked against a reference model, with random halt
`timescale 1ns/1ps
`include "bbox_macros.svh"

module tb_bbox;
    import bbox_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int LATENCY    = 3;
    localparam int N_BASE     = 8;
    localparam int N_CLIP     = 4;
    localparam int N_DROP     = 12;
    localparam int N_RAND     = 60;
    // Base set once at 1x, then again under all four msaa settings
    localparam int NUM_TRI    = N_BASE * 5 + N_CLIP + N_DROP + N_RAND;
    localparam int W_FRONT    = 0;
    localparam int W_BACK     = 1;
    localparam int W_ANY      = 2;
    localparam int FIELDS     = 10;

    // One scoreboard entry, field k sits at bits k*SIGFIG upward
    typedef logic [FIELDS*`BB_SIGFIG-1:0] entry_t;

    logic   clk;
    logic   rst_n;
    coord_t v0_x;
    coord_t v0_y;
    coord_t v1_x;
    coord_t v1_y;
    coord_t v2_x;
    coord_t v2_y;
    logic   in_valid;
    logic   in_ready;
    coord_t screen_w;
    coord_t screen_h;
    msaa_t  msaa;
    logic   halt;
    logic   out_valid;
    coord_t box_ll_x;
    coord_t box_ll_y;
    coord_t box_ur_x;
    coord_t box_ur_y;
    coord_t out_v0_x;
    coord_t out_v0_y;
    coord_t out_v1_x;
    coord_t out_v1_y;
    coord_t out_v2_x;
    coord_t out_v2_y;

    entry_t exp_q [$];
    int     acc_q [$];
    entry_t held;
    bit     held_prev     = 1'b0;
    bit     fixed_latency = 1'b0;
    bit     random_halt   = 1'b0;
    int     cyc           = 0;
    coord_t gen_v [6];
    coord_t bank [N_BASE][6];
    string  field_name [FIELDS] = '{"box_ll_x", "box_ll_y", "box_ur_x", "box_ur_y",
                                    "out_v0_x", "out_v0_y", "out_v1_x", "out_v1_y",
                                    "out_v2_x", "out_v2_y"};

    bbox_top uut (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Rising-edge count, used to time each triangle through the pipe
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        if (got != exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic coord_t field_of(input entry_t e, input int k);
        return coord_t'(e[k*`BB_SIGFIG +: `BB_SIGFIG]);
    endfunction

    // Whole pixels to fixed point
    function automatic int px(input int p);
        return p * (1 << `BB_RADIX);
    endfunction

    // z of (v1 - v0) x (v2 - v0)
    function automatic longint cross_of(input coord_t x0, y0, x1, y1, x2, y2);
        longint ax;
        longint ay;
        longint bx;
        longint by;
        ax = longint'(x1) - longint'(x0);
        ay = longint'(y1) - longint'(y0);
        bx = longint'(x2) - longint'(x0);
        by = longint'(y2) - longint'(y0);
        return ax * by - ay * bx;
    endfunction

    // Fraction bits kept below the grid step, log2 of the step
    function automatic int grid_shift(input msaa_t m);
        case (m)
            4'b1000: return `BB_RADIX;
            4'b0100: return `BB_RADIX - 1;
            4'b0010: return `BB_RADIX - 2;
            default: return `BB_RADIX - 3;
        endcase
    endfunction

    // Min and max, floored to the grid, off-screen test, then clip
    function automatic void axis_ref(input coord_t c0, c1, c2, lim, input int sh,
                                     output coord_t lo, hi, output bit off);
        coord_t mn;
        coord_t mx;
        mn = c0;
        mx = c0;
        if (c1 < mn) mn = c1;
        if (c2 < mn) mn = c2;
        if (c1 > mx) mx = c1;
        if (c2 > mx) mx = c2;
        mn = (mn >>> sh) <<< sh;
        mx = (mx >>> sh) <<< sh;
        off = (mn > lim) || (mx < 0);
        lo  = (mn < 0) ? coord_t'(0) : mn;
        hi  = (mx > lim) ? lim : mx;
    endfunction

    // Expected output fields and the keep decision for one triangle
    function automatic bit ref_model(input coord_t x0, y0, x1, y1, x2, y2,
                                     input msaa_t m, output entry_t e);
        coord_t lo_x;
        coord_t hi_x;
        coord_t lo_y;
        coord_t hi_y;
        bit     off_x;
        bit     off_y;
        axis_ref(x0, x1, x2, screen_w, grid_shift(m), lo_x, hi_x, off_x);
        axis_ref(y0, y1, y2, screen_h, grid_shift(m), lo_y, hi_y, off_y);
        e = {y2, x2, y1, x1, y0, x0, hi_y, hi_x, lo_y, lo_x};
        return !off_x && !off_y && (cross_of(x0, y0, x1, y1, x2, y2) <= 0);
    endfunction

    // Swapping vertices 1 and 2 flips the winding
    task automatic orient_tri(input int winding);
        longint cz;
        coord_t t;
        cz = cross_of(gen_v[0], gen_v[1], gen_v[2], gen_v[3], gen_v[4], gen_v[5]);
        if ((winding == W_FRONT && cz > 0) || (winding == W_BACK && cz < 0)) begin
            t        = gen_v[2];
            gen_v[2] = gen_v[4];
            gen_v[4] = t;
            t        = gen_v[3];
            gen_v[3] = gen_v[5];
            gen_v[5] = t;
        end
    endtask

    // Random vertices inside a pixel window, fraction bits random too
    task automatic gen_tri(input int x_lo, x_hi, y_lo, y_hi, input int winding);
        int span_x;
        int span_y;
        int k;
        span_x = px(x_hi - x_lo);
        span_y = px(y_hi - y_lo);
        for (k = 0; k < 3; k++) begin
            gen_v[2*k]   = coord_t'(px(x_lo) + int'($urandom % span_x));
            gen_v[2*k+1] = coord_t'(px(y_lo) + int'($urandom % span_y));
        end
        orient_tri(winding);
    endtask

    task automatic set_tri(input int x0, y0, x1, y1, x2, y2);
        gen_v = '{coord_t'(x0), coord_t'(y0), coord_t'(x1), coord_t'(y1),
                  coord_t'(x2), coord_t'(y2)};
        orient_tri(W_FRONT);
    endtask

    // Offer gen_v until taken, entered and left 2 ns after a rising edge
    task automatic send_tri();
        bit taken;
        v0_x     = gen_v[0];
        v0_y     = gen_v[1];
        v1_x     = gen_v[2];
        v1_y     = gen_v[3];
        v2_x     = gen_v[4];
        v2_y     = gen_v[5];
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    // Wait for all kept triangles, then flush bubbles through the three stages
    task automatic drain_pipe();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (LATENCY + 1) @(posedge clk);
        #2;
    endtask

    initial begin : halt_gen
        halt = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            halt = random_halt && (($urandom % 3) == 0);
        end
    end

    // Everything is settled at the falling edge
    always @(negedge clk) begin : monitor
        entry_t got;
        entry_t exp_e;
        int     acc;
        int     k;
        got = {out_v2_y, out_v2_x, out_v1_y, out_v1_x, out_v0_y, out_v0_x,
               box_ur_y, box_ur_x, box_ll_y, box_ll_x};
        if (rst_n) begin
            // Halted result from last cycle must not have moved
            if (held_prev) begin
                check_value("out_valid", out_valid, 1);
                for (k = 0; k < FIELDS; k++) begin
                    check_value(field_name[k], field_of(got, k), field_of(held, k));
                end
            end
            check_value("in_ready", in_ready, !(out_valid && halt));
            // Output taken at the coming rising edge
            if (out_valid && !halt) begin
                if (exp_q.size() == 0) begin
                    abort_run("DUT presented a triangle that the scoreboard did not expect");
                end else begin
                    exp_e = exp_q.pop_front();
                    acc   = acc_q.pop_front();
                    for (k = 0; k < FIELDS; k++) begin
                        check_value(field_name[k], field_of(got, k), field_of(exp_e, k));
                    end
                    if (fixed_latency) begin
                        check_value("latency", cyc - acc, LATENCY);
                    end
                end
            end
            // Input accepted at the coming rising edge
            if (in_valid && in_ready) begin
                if (ref_model(v0_x, v0_y, v1_x, v1_y, v2_x, v2_y, msaa, exp_e)) begin
                    exp_q.push_back(exp_e);
                    acc_q.push_back(cyc);
                end
            end
        end
        held_prev = out_valid && halt;
        held      = got;
    end

    initial begin : watchdog
        #(NUM_TRI * 20 * CLK_PERIOD);
        abort_run("Timeout, the pipeline stopped delivering triangles");
    end

    initial begin : main
        int    seed_dummy;
        int    i;
        int    j;
        msaa_t modes [4];
        modes      = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};
        seed_dummy = $urandom(32'h581167cb);
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        v0_x       = '0;
        v0_y       = '0;
        v1_x       = '0;
        v1_y       = '0;
        v2_x       = '0;
        v2_y       = '0;
        // Largest visible coordinate of a 640x480 screen
        screen_w   = coord_t'(px(640) - 1);
        screen_h   = coord_t'(px(480) - 1);
        msaa       = 4'b1000;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 1);
        @(posedge clk);
        #2;

        // On-screen front-facing set at 1x, three-cycle latency checked
        fixed_latency = 1'b1;
        for (i = 0; i < N_BASE; i++) begin
            gen_tri(0, 640, 0, 480, W_FRONT);
            bank[i] = gen_v;
            send_tri();
        end
        drain_pipe();

        // Same set under each grid step, msaa only moves with the pipe empty
        for (j = 0; j < 4; j++) begin
            msaa = modes[j];
            for (i = 0; i < N_BASE; i++) begin
                gen_v = bank[i];
                send_tri();
            end
            drain_pipe();
        end

        // Crossing left, bottom, right and top edges at 4x
        msaa = 4'b0100;
        set_tri(px(-40) + 317, px(100), px(60), px(120) + 5, px(20) + 700, px(200));
        send_tri();
        set_tri(px(100) + 77, px(-30) - 9, px(200), px(50), px(150), px(80) + 600);
        send_tri();
        set_tri(px(600) + 3, px(100), px(700) + 411, px(150), px(620), px(220) + 90);
        send_tri();
        set_tri(px(300), px(450) + 250, px(380) + 1, px(520), px(340), px(400) + 12);
        send_tri();
        drain_pipe();

        // Kept, off-screen and back-facing triangles interleaved
        for (i = 0; i < N_DROP; i++) begin
            case (i % 3)
                0: gen_tri(0, 640, 0, 480, W_FRONT);
                1: begin
                    case ((i / 3) % 4)
                        0: gen_tri(-300, -5, 0, 480, W_FRONT);
                        1: gen_tri(0, 640, -300, -5, W_FRONT);
                        2: gen_tri(650, 900, 0, 480, W_FRONT);
                        default: gen_tri(0, 640, 490, 800, W_FRONT);
                    endcase
                end
                default: gen_tri(0, 640, 0, 480, W_BACK);
            endcase
            send_tri();
        end
        drain_pipe();

        // Random triangles around the screen with random halt
        fixed_latency = 1'b0;
        random_halt   = 1'b1;
        msaa          = 4'b0010;
        for (i = 0; i < N_RAND; i++) begin
            gen_tri(-100, 740, -100, 580, W_ANY);
            send_tri();
        end
        drain_pipe();
        random_halt = 1'b0;
        repeat (2) @(posedge clk);

        if (exp_q.size() != 0) begin
            abort_run("Scoreboard still holds triangles that never came out");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- tri_setup.sv
// First pipeline stage, captures an incoming triangle and its edge vectors
// Feeds the per-axis bound units and the facing test
`timescale 1ns/1ps
`include "bbox_macros.svh"

module tri_setup (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stage_en,
    input  bbox_pkg::coord_t v0_x,
    input  bbox_pkg::coord_t v0_y,
    input  bbox_pkg::coord_t v1_x,
    input  bbox_pkg::coord_t v1_y,
    input  bbox_pkg::coord_t v2_x,
    input  bbox_pkg::coord_t v2_y,
    input  logic             in_valid,
    output bbox_pkg::coord_t x_0,
    output bbox_pkg::coord_t x_1,
    output bbox_pkg::coord_t x_2,
    output bbox_pkg::coord_t y_0,
    output bbox_pkg::coord_t y_1,
    output bbox_pkg::coord_t y_2,
    output logic             s1_valid,
    output bbox_pkg::coord_t ax,
    output bbox_pkg::coord_t ay,
    output bbox_pkg::coord_t bx,
    output bbox_pkg::coord_t by
);
    import bbox_pkg::*;

    // Edge vectors relative to vertex 0
    // A = v1 - v0, B = v2 - v0
    coord_t edge_ax;
    coord_t edge_ay;
    coord_t edge_bx;
    coord_t edge_by;

    assign edge_ax = v1_x - v0_x;
    assign edge_ay = v1_y - v0_y;
    assign edge_bx = v2_x - v0_x;
    assign edge_by = v2_y - v0_y;

    // Valid flag, bubbles also advance whenever the pipe moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (stage_en) begin
            s1_valid <= in_valid;
        end
    end

    // Vertex and edge payload
    // Subtraction done here so the multiply gets a full cycle next stage
    always_ff @(posedge clk) begin
        if (stage_en) begin
            x_0 <= v0_x;
            x_1 <= v1_x;
            x_2 <= v2_x;
            y_0 <= v0_y;
            y_1 <= v1_y;
            y_2 <= v2_y;
            ax  <= edge_ax;
            ay  <= edge_ay;
            bx  <= edge_bx;
            by  <= edge_by;
        end
    end

endmodule
